// ==== tb.f ====
+incdir+logic
logic/tpu_pkg.sv
logic/ring_buff_ctrl.sv
logic/extern_handle.sv
logic/data_mem_access.sv
logic/extern_port_top.sv
dv/extern_port_sva.sv
dv/extern_port_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vextern_port_tb

.PHONY: all run clean

all: run

$(SIM): tb.f $(wildcard logic/*.sv logic/*.svh dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module extern_port_tb -f tb.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== dv/extern_port_tb.sv ====
`timescale 1ns/1ns
`include "tpu_params.svh"

module extern_port_tb;

	localparam int TIMEOUT_CYCLES = 2000;

	logic				clock;
	logic				reset;
	logic				in_req;
	tpu_pkg::data_t		in_data;
	logic				in_rls;
	logic				out_req;
	tpu_pkg::data_t		out_data;
	logic				out_rls;
	logic				buff_full;

	logic [31:0]		lfsr_state;
	int					cycle_count;
	tpu_pkg::data_t		mem_model [`TPU_MEM_DEPTH];	// Expected data memory

	extern_port_top DUT (
		.clock(clock), .reset(reset),
		.in_req(in_req), .in_data(in_data), .in_rls(in_rls),
		.out_req(out_req), .out_data(out_data), .out_rls(out_rls),
		.buff_full(buff_full)
	);

	bind extern_handle extern_port_sva u_extern_port_sva (
		.clock(clock), .reset(reset), .ld_req(ld_req), .st_req(st_req),
		.ld_term(ld_term), .out_req(out_req), .out_rls(out_rls), .in_req(in_req),
		.st_phase(st_phase), .full(full)
	);

	always #4 clock = ~clock;

	////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};	// x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_word(output tpu_pkg::data_t word);
		word = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			word = {word[30:0], lfsr_state[0]};	// One bit per step
		end
	endtask

	// Strided address, wrapped into the memory
	function automatic int word_address(input tpu_pkg::address_t base,
			input tpu_pkg::address_t stride, input int index);
		return int'((base + stride * index) % `TPU_MEM_DEPTH);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clock);
			in_req <= 1'b0;
		end
	endtask

	task automatic send_word(input tpu_pkg::data_t word);
		@(negedge clock);
		while (buff_full) begin
			@(posedge clock);
			in_req <= 1'b0;	// Hold data back
			@(negedge clock);
		end
		@(posedge clock);
		in_req <= 1'b1;
		in_data <= word;
	endtask

	// Open word, then stride with direction bit, length and base
	task automatic send_command(input logic load, input tpu_pkg::address_t stride,
			input tpu_pkg::address_t length, input tpu_pkg::address_t base);
		send_word('0);
		send_word({load, stride[30:0]});
		send_word(length);
		send_word(base);
	endtask

	task automatic store_words(input tpu_pkg::address_t base, input tpu_pkg::address_t stride,
			input int count, input bit gapped);
		tpu_pkg::data_t word;
		send_command(1'b0, stride, count, base);
		for (int i = 0; i < count; i++) begin
			draw_word(word);
			mem_model[word_address(base, stride, i)] = word;
			send_word(word);
			if (gapped) begin
				idle_cycles(i % 3 + 1);
			end
		end
		idle_cycles(1);
		@(negedge clock);
		while (!DUT.st_term) @(negedge clock);	// Last word written
	endtask

	task automatic start_load(input tpu_pkg::address_t base, input tpu_pkg::address_t stride,
			input tpu_pkg::address_t length);
		send_command(1'b1, stride, length, base);
		idle_cycles(1);
		@(negedge clock);
		while (!out_req) @(negedge clock);
	endtask

	task automatic expect_load_word(input tpu_pkg::address_t base,
			input tpu_pkg::address_t stride, input int index, input logic last);
		check_value("out_req", out_req, 1'b1);
		check_value("out_data", out_data, mem_model[word_address(base, stride, index)]);
		check_value("out_rls", out_rls, last);
	endtask

	task automatic load_and_compare(input tpu_pkg::address_t base,
			input tpu_pkg::address_t stride, input int length);
		start_load(base, stride, length);
		for (int i = 0; i < length; i++) begin
			if (i > 0) begin
				@(negedge clock);	// One word per cycle
			end
			expect_load_word(base, stride, i, i == length - 1);
		end
	endtask

	////////////////////////////////////////
	// Directed tests

	task automatic idle_after_reset();
		repeat (10) begin
			@(negedge clock);
			check_value("out_req", out_req, 1'b0);
			check_value("out_rls", out_rls, 1'b0);
			check_value("buff_full", buff_full, 1'b0);
		end
	endtask

	task automatic round_trip_unit_stride();
		store_words(32'd4, 32'd1, 8, 1'b0);
		load_and_compare(32'd4, 32'd1, 8);
	endtask

	// Gaps between stored words come back from the model
	task automatic strided_access();
		store_words(32'd20, 32'd3, 6, 1'b0);
		load_and_compare(32'd20, 32'd1, 18);
	endtask

	task automatic gapped_delivery();
		store_words(32'd240, 32'd2, 10, 1'b1);	// Wraps past the top
		load_and_compare(32'd240, 32'd2, 10);
	endtask

	task automatic release_abort();
		start_load(32'd4, 32'd1, 32'd12);
		for (int i = 0; i < 3; i++) begin
			if (i > 0) begin
				@(negedge clock);
			end
			expect_load_word(32'd4, 32'd1, i, 1'b0);
		end
		@(posedge clock);
		in_rls <= 1'b1;
		@(posedge clock);
		in_rls <= 1'b0;
		repeat (4) begin
			@(negedge clock);
			check_value("out_req", out_req, 1'b0);
		end
		load_and_compare(32'd20, 32'd1, 4);
	endtask

	////////////////////////////////////////
	// Run

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$fatal(1, "Timeout");
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		in_req = 1'b0;
		in_data = '0;
		in_rls = 1'b0;
		lfsr_state = 32'h909e;
		for (int i = 0; i < `TPU_MEM_DEPTH; i++) begin
			mem_model[i] = '0;
		end
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		idle_after_reset();
		round_trip_unit_stride();
		strided_access();
		gapped_delivery();
		release_abort();
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== dv/extern_port_sva.sv ====
`timescale 1ns/1ns

module extern_port_sva (
	input	logic	clock,
	input	logic	reset,
	input	logic	ld_req,
	input	logic	st_req,
	input	logic	ld_term,	// Last word from the engine
	input	logic	out_req,
	input	logic	out_rls,
	input	logic	in_req,
	input	logic	st_phase,	// Store words are being buffered
	input	logic	full
);

	// Only one config pulse or store strobe at a time
	ld_st_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(ld_req && st_req))
		else $error("ld_req and st_req high in the same cycle");

	// Engine's last word goes out to the agent with the release
	rls_with_req: assert property (@(posedge clock) disable iff (reset)
		ld_term |-> (out_req && out_rls))
		else $error("ld_term not forwarded as a released out word");

	// Agent holds store data while the buffer is full
	no_write_when_full: assert property (@(posedge clock) disable iff (reset)
		(in_req && st_phase) |-> !full)
		else $error("Store word offered while the buffer is full");

endmodule

// ==== logic/extern_port_top.sv ====
`timescale 1ns/1ns
`include "tpu_params.svh"

module extern_port_top (
	input	logic				clock,
	input	logic				reset,
	input	logic				in_req,
	input	tpu_pkg::data_t		in_data,
	input	logic				in_rls,
	output	logic				out_req,
	output	tpu_pkg::data_t		out_data,
	output	logic				out_rls,
	output	logic				buff_full	// Agent holds data while high
);

	////////////////////////////////////////
	// Handler to engine

	logic				abort;
	logic				ld_req;
	tpu_pkg::address_t	ld_length;
	tpu_pkg::address_t	ld_stride;
	tpu_pkg::address_t	ld_base;
	logic				ld_grant;
	tpu_pkg::data_t		ld_data;
	logic				ld_term;
	logic				st_req;
	tpu_pkg::address_t	st_length;
	tpu_pkg::address_t	st_stride;
	tpu_pkg::address_t	st_base;
	logic				st_grant;
	tpu_pkg::data_t		st_data;
	logic				st_term;

	extern_handle u_extern_handle (
		.clock(clock), .reset(reset),
		.in_req(in_req), .in_data(in_data), .in_rls(in_rls),
		.out_req(out_req), .out_data(out_data), .out_rls(out_rls),
		.buff_full(buff_full), .abort(abort),
		.ld_req(ld_req), .ld_length(ld_length), .ld_stride(ld_stride), .ld_base(ld_base),
		.ld_grant(ld_grant), .ld_data(ld_data), .ld_term(ld_term),
		.st_req(st_req), .st_length(st_length), .st_stride(st_stride), .st_base(st_base),
		.st_grant(st_grant), .st_data(st_data), .st_term(st_term)
	);

	// Engine and data memory
	data_mem_access #(
		.MEM_DEPTH(`TPU_MEM_DEPTH)
	) u_data_mem_access (
		.clock(clock), .reset(reset), .abort(abort),
		.ld_req(ld_req), .ld_length(ld_length), .ld_stride(ld_stride), .ld_base(ld_base),
		.ld_grant(ld_grant), .ld_data(ld_data), .ld_term(ld_term),
		.st_req(st_req), .st_length(st_length), .st_stride(st_stride), .st_base(st_base),
		.st_data(st_data), .st_grant(st_grant), .st_term(st_term)
	);

endmodule

// ==== logic/data_mem_access.sv ====
`timescale 1ns/1ns

module data_mem_access #(
	parameter int MEM_DEPTH = 256
)(
	input	logic					clock,
	input	logic					reset,
	input	logic					abort,
	input	logic					ld_req,
	input	tpu_pkg::address_t		ld_length,
	input	tpu_pkg::address_t		ld_stride,
	input	tpu_pkg::address_t		ld_base,
	output	logic					ld_grant,
	output	tpu_pkg::data_t			ld_data,
	output	logic					ld_term,	// With the last loaded word
	input	logic					st_req,
	input	tpu_pkg::address_t		st_length,
	input	tpu_pkg::address_t		st_stride,
	input	tpu_pkg::address_t		st_base,
	input	tpu_pkg::data_t			st_data,
	output	logic					st_grant,
	output	logic					st_term		// Cycle after the last write
);

	localparam int WIDTH_INDEX = $clog2(MEM_DEPTH);
	localparam tpu_pkg::address_t DEPTH = tpu_pkg::address_t'(MEM_DEPTH);

	tpu_pkg::fsm_access_t fsm_access;

	logic				mode_load;
	tpu_pkg::address_t	r_length;
	tpu_pkg::address_t	r_stride;	// Kept below DEPTH
	tpu_pkg::address_t	r_addr;		// Kept below DEPTH
	tpu_pkg::address_t	count;
	tpu_pkg::address_t	addr_sum;
	tpu_pkg::address_t	addr_next;

	logic [WIDTH_INDEX-1:0] index;

	logic is_idle;
	logic is_grant;
	logic is_load;
	logic is_store;
	logic step;
	logic last_word;

	tpu_pkg::data_t mem [MEM_DEPTH];

	assign is_idle = fsm_access == tpu_pkg::ACCESS_IDLE;
	assign is_grant = fsm_access == tpu_pkg::ACCESS_GRANT;
	assign is_load = fsm_access == tpu_pkg::ACCESS_LOAD;
	assign is_store = fsm_access == tpu_pkg::ACCESS_STORE;

	assign step = is_load | (is_store & st_req);	// Loads never stall
	assign last_word = (count + 1'b1) >= r_length;

	// Next strided address, wrapped into the array
	assign addr_sum = r_addr + r_stride;
	assign addr_next = (addr_sum >= DEPTH) ? addr_sum - DEPTH : addr_sum;
	assign index = r_addr[WIDTH_INDEX-1:0];

	assign ld_grant = is_grant & mode_load;
	assign st_grant = is_grant & ~mode_load;
	assign ld_data = mem[index];
	assign ld_term = is_load & last_word;

	initial begin
		for (int i = 0; i < MEM_DEPTH; i++) begin
			mem[i] = '0;	// Cleared at power-up
		end
	end

	always_ff @(posedge clock) begin
		if (is_store && st_req) begin
			mem[index] <= st_data;
		end
	end

	// Config latch and address walk
	always_ff @(posedge clock) begin
		if (is_idle && (ld_req || st_req)) begin
			mode_load <= ld_req;
			r_length <= ld_req ? ld_length : st_length;
			r_stride <= (ld_req ? ld_stride : st_stride) % DEPTH;
			r_addr <= (ld_req ? ld_base : st_base) % DEPTH;
			count <= '0;
		end else if (step) begin
			r_addr <= addr_next;
			count <= count + 1'b1;
		end
	end

	////////////////////////////////////////
	// Access FSM
	always_ff @(posedge clock) begin
		if (reset || abort) begin
			fsm_access <= tpu_pkg::ACCESS_IDLE;
		end else begin
			case (fsm_access)
				tpu_pkg::ACCESS_IDLE: begin
					if (ld_req || st_req) fsm_access <= tpu_pkg::ACCESS_GRANT;
				end
				tpu_pkg::ACCESS_GRANT: begin
					fsm_access <= mode_load ? tpu_pkg::ACCESS_LOAD : tpu_pkg::ACCESS_STORE;
				end
				tpu_pkg::ACCESS_LOAD: if (last_word) fsm_access <= tpu_pkg::ACCESS_IDLE;
				tpu_pkg::ACCESS_STORE: begin
					if (st_req && last_word) fsm_access <= tpu_pkg::ACCESS_IDLE;
				end
				default: fsm_access <= tpu_pkg::ACCESS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset || abort) begin
			st_term <= 1'b0;
		end else begin
			st_term <= is_store & st_req & last_word;
		end
	end

endmodule

// ==== logic/extern_handle.sv ====
`timescale 1ns/1ns
`include "tpu_params.svh"

module extern_handle (
	input	logic					clock,
	input	logic					reset,
	input	logic					in_req,		// Word strobe from agent
	input	tpu_pkg::data_t			in_data,
	input	logic					in_rls,		// Release from agent
	output	logic					out_req,	// Word strobe to agent
	output	tpu_pkg::data_t			out_data,
	output	logic					out_rls,	// Last loaded word
	output	logic					buff_full,
	output	logic					abort,		// Engine abort on release
	output	logic					ld_req,
	output	tpu_pkg::address_t		ld_length,
	output	tpu_pkg::address_t		ld_stride,
	output	tpu_pkg::address_t		ld_base,
	input	logic					ld_grant,
	input	tpu_pkg::data_t			ld_data,
	input	logic					ld_term,
	output	logic					st_req,		// Config pulse, then data strobe
	output	tpu_pkg::address_t		st_length,
	output	tpu_pkg::address_t		st_stride,
	output	tpu_pkg::address_t		st_base,
	input	logic					st_grant,
	output	tpu_pkg::data_t			st_data,
	input	logic					st_term
);

	localparam int WIDTH_BUFF = $clog2(`TPU_BUFF_SIZE);

	tpu_pkg::fsm_extern_t		fsm_extern;
	tpu_pkg::fsm_extern_st_t	fsm_st;
	tpu_pkg::fsm_extern_ld_t	fsm_ld;

	tpu_pkg::address_t	r_stride;
	tpu_pkg::address_t	r_length;
	tpu_pkg::address_t	r_base;
	logic				r_dir_load;	// Top bit of the stride word
	tpu_pkg::address_t	st_count;	// Words handed to the engine

	logic is_recv_set;
	logic is_run;
	logic ld_config;
	logic st_config;
	logic st_phase;
	logic st_drain;
	logic ld_run;
	logic buff_we;
	logic buff_clear;

	logic [WIDTH_BUFF-1:0]	wr_ptr;
	logic [WIDTH_BUFF-1:0]	rd_ptr;
	logic					full;
	logic					empty;

	tpu_pkg::data_t buff [`TPU_BUFF_SIZE];

	assign is_recv_set = fsm_extern == tpu_pkg::EXTERN_RECV_SET;
	assign is_run = fsm_extern == tpu_pkg::EXTERN_RUN;
	assign ld_config = is_recv_set & r_dir_load;
	assign st_config = is_recv_set & ~r_dir_load;
	assign abort = is_run & in_rls;

	// Store words are buffered from RECV_SET onward
	assign st_phase = ~r_dir_load & (is_recv_set | is_run);
	assign buff_we = in_req & st_phase & ~full;
	assign buff_clear = abort | st_term;

	// Drain stops after length words even if the agent overruns
	assign st_drain = (fsm_st == tpu_pkg::ST_RUN) & ~empty & (st_count != r_length);
	assign ld_run = fsm_ld == tpu_pkg::LD_RUN;

	////////////////////////////////////////
	// Engine side
	assign ld_req = ld_config;
	assign ld_length = r_length;
	assign ld_stride = r_stride;
	assign ld_base = r_base;

	assign st_req = st_config | st_drain;
	assign st_length = r_length;
	assign st_stride = r_stride;
	assign st_base = r_base;
	assign st_data = buff[rd_ptr];

	////////////////////////////////////////
	// Agent side
	assign out_req = ld_run;
	assign out_data = ld_run ? ld_data : '0;
	assign out_rls = ld_run & ld_term;
	assign buff_full = full;

	// Command words, captured as they arrive
	always_ff @(posedge clock) begin
		if (in_req) begin
			case (fsm_extern)
				tpu_pkg::EXTERN_RECV_STRIDE: r_stride <= {1'b0, in_data[`TPU_WIDTH_DATA-2:0]};
				tpu_pkg::EXTERN_RECV_LENGTH: r_length <= in_data;
				tpu_pkg::EXTERN_RECV_BASE: r_base <= in_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			r_dir_load <= 1'b0;
		end else if (in_req && fsm_extern == tpu_pkg::EXTERN_RECV_STRIDE) begin
			r_dir_load <= in_data[`TPU_WIDTH_DATA-1];	// 1 selects load
		end
	end

	always_ff @(posedge clock) begin
		if (reset || is_recv_set) begin
			st_count <= '0;
		end else if (st_drain) begin
			st_count <= st_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (buff_we) begin
			buff[wr_ptr] <= in_data;
		end
	end

	////////////////////////////////////////
	// Command machine
	always_ff @(posedge clock) begin
		if (reset) begin
			fsm_extern <= tpu_pkg::EXTERN_INIT;
		end else begin
			case (fsm_extern)
				tpu_pkg::EXTERN_INIT: begin
					if (in_req) fsm_extern <= tpu_pkg::EXTERN_RECV_STRIDE;	// Open word
				end
				tpu_pkg::EXTERN_RECV_STRIDE: begin
					if (in_req) fsm_extern <= tpu_pkg::EXTERN_RECV_LENGTH;
				end
				tpu_pkg::EXTERN_RECV_LENGTH: begin
					if (in_req) fsm_extern <= tpu_pkg::EXTERN_RECV_BASE;
				end
				tpu_pkg::EXTERN_RECV_BASE: begin
					if (in_req) fsm_extern <= tpu_pkg::EXTERN_RECV_SET;
				end
				tpu_pkg::EXTERN_RECV_SET: fsm_extern <= tpu_pkg::EXTERN_RUN;
				tpu_pkg::EXTERN_RUN: begin
					if (ld_term || st_term || in_rls) fsm_extern <= tpu_pkg::EXTERN_INIT;
				end
				default: fsm_extern <= tpu_pkg::EXTERN_INIT;
			endcase
		end
	end

	// Store control
	always_ff @(posedge clock) begin
		if (reset || abort) begin
			fsm_st <= tpu_pkg::ST_INIT;
		end else begin
			case (fsm_st)
				tpu_pkg::ST_INIT: if (st_config) fsm_st <= tpu_pkg::ST_BUFF;
				tpu_pkg::ST_BUFF: if (st_grant) fsm_st <= tpu_pkg::ST_RUN;
				tpu_pkg::ST_RUN: if (st_term) fsm_st <= tpu_pkg::ST_INIT;
				default: fsm_st <= tpu_pkg::ST_INIT;
			endcase
		end
	end

	// Load control
	always_ff @(posedge clock) begin
		if (reset || abort) begin
			fsm_ld <= tpu_pkg::LD_INIT;
		end else begin
			case (fsm_ld)
				tpu_pkg::LD_INIT: if (ld_config) fsm_ld <= tpu_pkg::LD_WAIT;
				tpu_pkg::LD_WAIT: if (ld_grant) fsm_ld <= tpu_pkg::LD_RUN;
				tpu_pkg::LD_RUN: if (ld_term) fsm_ld <= tpu_pkg::LD_INIT;
				default: fsm_ld <= tpu_pkg::LD_INIT;
			endcase
		end
	end

	ring_buff_ctrl #(
		.NUM_ENTRY	(`TPU_BUFF_SIZE)
	) u_ring_buff_ctrl (
		.clock		(clock),
		.reset		(reset),
		.clear		(buff_clear),
		.we			(buff_we),
		.re			(st_drain),
		.wr_ptr		(wr_ptr),
		.rd_ptr		(rd_ptr),
		.full		(full),
		.empty		(empty),
		.num		()
	);

endmodule

// ==== logic/ring_buff_ctrl.sv ====
`timescale 1ns/1ns

module ring_buff_ctrl #(
	parameter int NUM_ENTRY = 16
)(
	input	logic							clock,
	input	logic							reset,
	input	logic							clear,	// Drop all entries
	input	logic							we,
	input	logic							re,
	output	logic [$clog2(NUM_ENTRY)-1:0]	wr_ptr,
	output	logic [$clog2(NUM_ENTRY)-1:0]	rd_ptr,
	output	logic							full,
	output	logic							empty,
	output	logic [$clog2(NUM_ENTRY):0]		num		// Occupancy
);

	localparam int WIDTH_PTR = $clog2(NUM_ENTRY);
	localparam logic [WIDTH_PTR-1:0] LAST_PTR = WIDTH_PTR'(NUM_ENTRY - 1);
	localparam logic [WIDTH_PTR:0] FULL_NUM = (WIDTH_PTR + 1)'(NUM_ENTRY);

	logic do_write;
	logic do_read;

	assign full = num == FULL_NUM;
	assign empty = num == '0;
	assign do_write = we & ~full;	// Dropped when full
	assign do_read = re & ~empty;

	// Pointers wrap at the last entry
	always_ff @(posedge clock) begin
		if (reset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			num <= '0;
		end else if (do_write && !do_read) begin
			num <= num + 1'b1;
		end else if (do_read && !do_write) begin
			num <= num - 1'b1;
		end
	end

endmodule

// ==== logic/tpu_pkg.sv ====
`include "tpu_params.svh"

package tpu_pkg;

	typedef logic [`TPU_WIDTH_DATA-1:0]	data_t;		// One data word
	typedef logic [`TPU_WIDTH_DATA-1:0]	address_t;	// Address, stride or length

	////////////////////////////////////////
	// State machines

	// Command intake, one state per command word
	typedef enum logic [2:0] {
		EXTERN_INIT, EXTERN_RECV_STRIDE, EXTERN_RECV_LENGTH,
		EXTERN_RECV_BASE, EXTERN_RECV_SET, EXTERN_RUN
	} fsm_extern_t;

	typedef enum logic [1:0] {ST_INIT, ST_BUFF, ST_RUN} fsm_extern_st_t;	// Store side

	typedef enum logic [1:0] {LD_INIT, LD_WAIT, LD_RUN} fsm_extern_ld_t;	// Load side

	// Memory access engine
	typedef enum logic [1:0] {
		ACCESS_IDLE, ACCESS_GRANT, ACCESS_LOAD, ACCESS_STORE
	} fsm_access_t;

endpackage

// ==== logic/tpu_params.svh ====
`ifndef TPU_PARAMS_SVH
`define TPU_PARAMS_SVH

////////////////////////////////////////
// Word widths

// Data and address words share one width
`define TPU_WIDTH_DATA	32

////////////////////////////////////////
// Storage sizes

// Store buffer in the port handler
`define TPU_BUFF_SIZE	16

`define TPU_MEM_DEPTH	256	// Data memory words

`endif
